//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_bulk_bridge
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- axil_master.sv
`include "bulk_bridge_consts.svh"

module axil_master
  import bulk_bridge_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    op_valid_i,
  input  mem_op_t                 op_i,
  output logic                    op_ready_o,
  output logic                    awvalid_o,
  input  logic                    awready_i,
  output logic [`BB_ADDR_W-1:0]   awaddr_o,
  output logic                    wvalid_o,
  input  logic                    wready_i,
  output logic [`BB_DATA_W-1:0]   wdata_o,
  output logic [`BB_DATA_W/8-1:0] wstrb_o,
  input  logic                    bvalid_i,
  output logic                    bready_o,
  input  logic [1:0]              bresp_i,
  output logic                    arvalid_o,
  input  logic                    arready_i,
  output logic [`BB_ADDR_W-1:0]   araddr_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,
  input  logic [`BB_DATA_W-1:0]   rdata_i,
  input  logic [1:0]              rresp_i,
  output logic                    rd_valid_o,
  output rd_word_t                rd_o,
  input  logic                    rd_ready_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} state_t;

  state_t  state;
  mem_op_t op_q;
  logic    r_phase;

  assign op_ready_o = (state == ST_IDLE);

  assign awaddr_o = op_q.addr;
  assign araddr_o = op_q.addr;
  assign wdata_o  = op_q.wdata;
  assign wstrb_o  = '1;

  // Responses are taken only once the request side is done
  assign bready_o = (state == ST_WRITE) && !awvalid_o && !wvalid_o;
  assign r_phase  = (state == ST_READ) && !arvalid_o;

  // R passes straight through to the packer
  assign rd_valid_o   = r_phase && rvalid_i;
  assign rready_o     = r_phase && rd_ready_i;
  assign rd_o.last_word = op_q.last_word;
  assign rd_o.data      = rdata_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_IDLE;
      awvalid_o <= 1'b0;
      wvalid_o  <= 1'b0;
      arvalid_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (op_valid_i) begin
            if (op_i.is_read) begin
              arvalid_o <= 1'b1;
              state     <= ST_READ;
            end else begin
              awvalid_o <= 1'b1;
              wvalid_o  <= 1'b1;
              state     <= ST_WRITE;
            end
          end
        end
        ST_WRITE: begin
          if (awvalid_o && awready_i) begin
            awvalid_o <= 1'b0;
          end
          if (wvalid_o && wready_i) begin
            wvalid_o <= 1'b0;
          end
          if (bvalid_i && bready_o) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          if (arvalid_o && arready_i) begin
            arvalid_o <= 1'b0;
          end
          if (rvalid_i && rready_o) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (op_valid_i && op_ready_o) begin
      op_q <= op_i;
    end
  end

  a_aw_hold: assert property (@(posedge clock) disable iff (reset)
    (awvalid_o && !awready_i) |=> awvalid_o);
  a_ar_hold: assert property (@(posedge clock) disable iff (reset)
    (arvalid_o && !arready_i) |=> arvalid_o);

endmodule

//--- axil_sram.sv
`include "bulk_bridge_consts.svh"

module axil_sram #(
  parameter int WORDS = `BB_MEM_WORDS
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  logic [`BB_ADDR_W-1:0]   awaddr_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  input  logic [`BB_DATA_W-1:0]   wdata_i,
  input  logic [`BB_DATA_W/8-1:0] wstrb_i,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  output logic [1:0]              bresp_o,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  input  logic [`BB_ADDR_W-1:0]   araddr_i,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output logic [`BB_DATA_W-1:0]   rdata_o,
  output logic [1:0]              rresp_o
);

  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  logic [`BB_DATA_W-1:0] mem [WORDS];
  logic [IDX_W-1:0]      wr_idx;
  logic [IDX_W-1:0]      rd_idx;
  logic                  write_en;
  logic                  read_en;

  // Word address, wrapped to the memory depth
  assign wr_idx = IDX_W'(awaddr_i[`BB_ADDR_W-1:2] % WORDS);
  assign rd_idx = IDX_W'(araddr_i[`BB_ADDR_W-1:2] % WORDS);

  // Address and data are taken together, and only with no B pending
  assign write_en  = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = write_en;
  assign wready_o  = write_en;
  assign arready_o = !rvalid_o;
  assign read_en   = arvalid_i && arready_o;

  assign bresp_o = 2'b00;
  assign rresp_o = 2'b00;

  always_ff @(posedge clock) begin
    if (reset) begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (write_en) begin
        bvalid_o <= 1'b1;
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end
      if (read_en) begin
        rvalid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (write_en) begin
      for (int b = 0; b < `BB_DATA_W / 8; b++) begin
        if (wstrb_i[b]) begin
          mem[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (read_en) begin
      rdata_o <= mem[rd_idx];
    end
  end

endmodule

//--- bulk_bridge_consts.svh
`ifndef BULK_BRIDGE_CONSTS_SVH
`define BULK_BRIDGE_CONSTS_SVH

// AXI4-Lite data path and byte address
`define BB_DATA_W 32
`define BB_ADDR_W 18

// On-chip SRAM depth in words
`define BB_MEM_WORDS 256

// Queue depths between the stages
`define BB_OP_FIFO_DEPTH 4
`define BB_IN_FIFO_DEPTH 16

// Command opcodes, first byte of each OUT packet
`define BB_OPC_WRITE 8'h01
`define BB_OPC_READ 8'h02

`endif

//--- bulk_bridge_patterns.txt
# name kind(W/R) word_addr(hex) count(hex) then 4*count bytes (hex), low byte first
# W lines carry the data to write, R lines carry the expected IN bytes
wr_block W 0010 04 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 00
rd_block R 0010 04 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 00
rd_one R 0012 01 99 aa bb cc
rd_mid R 0011 02 55 66 77 88 99 aa bb cc
wr_alias W 012c 02 de ad be ef 01 02 03 04
rd_alias R 002c 02 de ad be ef 01 02 03 04
rd_alias_hi R 022d 01 01 02 03 04
wr_wrap W 00ff 02 f0 f1 f2 f3 e0 e1 e2 e3
rd_wrap R 00ff 02 f0 f1 f2 f3 e0 e1 e2 e3
rd_wrap_low R 0000 01 e0 e1 e2 e3
wr_first W 0040 03 a0 a1 a2 a3 b0 b1 b2 b3 c0 c1 c2 c3
wr_second W 0041 01 5a 5b 5c 5d
wr_third W 0041 01 6a 6b 6c 6d
rd_order R 0040 03 a0 a1 a2 a3 6a 6b 6c 6d c0 c1 c2 c3
wr_big W 0080 05 10 11 12 13 20 21 22 23 30 31 32 33 40 41 42 43 50 51 52 53
rd_big R 0080 05 10 11 12 13 20 21 22 23 30 31 32 33 40 41 42 43 50 51 52 53
rd_big_tail R 0082 03 30 31 32 33 40 41 42 43 50 51 52 53
wr_patch W 0081 01 77 66 55 44
rd_patch R 0080 02 10 11 12 13 77 66 55 44

//--- bulk_bridge_pkg.sv
`include "bulk_bridge_consts.svh"

package bulk_bridge_pkg;

  // One byte of the IN stream with its end-of-packet flag
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } stream_beat_t;

  // One single-word memory access
  typedef struct packed {
    logic                  is_read;
    logic                  last_word;
    logic [`BB_ADDR_W-1:0] addr;
    logic [`BB_DATA_W-1:0] wdata;
  } mem_op_t;

  // Read data on its way back to the host
  typedef struct packed {
    logic                  last_word;
    logic [`BB_DATA_W-1:0] data;
  } rd_word_t;

endpackage

//--- bulk_bridge_top.sv
`include "bulk_bridge_consts.svh"

module bulk_bridge_top
  import bulk_bridge_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       s_tvalid_i,
  input  logic [7:0] s_tdata_i,
  input  logic       s_tlast_i,
  output logic       s_tready_o,
  output logic       m_tvalid_o,
  output logic [7:0] m_tdata_o,
  output logic       m_tlast_o,
  input  logic       m_tready_i
);

  mem_op_t                 cmd_op;
  mem_op_t                 exec_op;
  rd_word_t                rd_word;
  stream_beat_t            beat;
  stream_beat_t            in_beat;
  logic                    cmd_op_valid;
  logic                    cmd_op_ready;
  logic                    exec_op_valid;
  logic                    exec_op_ready;
  logic                    rd_valid;
  logic                    rd_ready;
  logic                    beat_valid;
  logic                    beat_ready;
  logic                    awvalid;
  logic                    awready;
  logic                    wvalid;
  logic                    wready;
  logic                    bvalid;
  logic                    bready;
  logic                    arvalid;
  logic                    arready;
  logic                    rvalid;
  logic                    rready;
  logic [`BB_ADDR_W-1:0]   awaddr;
  logic [`BB_ADDR_W-1:0]   araddr;
  logic [`BB_DATA_W-1:0]   wdata;
  logic [`BB_DATA_W-1:0]   rdata;
  logic [`BB_DATA_W/8-1:0] wstrb;
  logic [1:0]              bresp;
  logic [1:0]              rresp;

  // Packet length comes from the header, so s_tlast_i is not needed for framing
  assign m_tdata_o = in_beat.data;
  assign m_tlast_o = in_beat.last;

  command_parser command_parser_inst (
    .clock      (clock),
    .reset      (reset),
    .s_tvalid_i (s_tvalid_i),
    .s_tdata_i  (s_tdata_i),
    .s_tready_o (s_tready_o),
    .op_valid_o (cmd_op_valid),
    .op_o       (cmd_op),
    .op_ready_i (cmd_op_ready)
  );

  stream_fifo #(
    .payload_t (mem_op_t),
    .DEPTH     (`BB_OP_FIFO_DEPTH)
  ) op_fifo (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (cmd_op_valid),
    .in_data_i   (cmd_op),
    .in_ready_o  (cmd_op_ready),
    .out_valid_o (exec_op_valid),
    .out_data_o  (exec_op),
    .out_ready_i (exec_op_ready)
  );

  axil_master axil_master_inst (
    .clock      (clock),
    .reset      (reset),
    .op_valid_i (exec_op_valid),
    .op_i       (exec_op),
    .op_ready_o (exec_op_ready),
    .awvalid_o  (awvalid),
    .awready_i  (awready),
    .awaddr_o   (awaddr),
    .wvalid_o   (wvalid),
    .wready_i   (wready),
    .wdata_o    (wdata),
    .wstrb_o    (wstrb),
    .bvalid_i   (bvalid),
    .bready_o   (bready),
    .bresp_i    (bresp),
    .arvalid_o  (arvalid),
    .arready_i  (arready),
    .araddr_o   (araddr),
    .rvalid_i   (rvalid),
    .rready_o   (rready),
    .rdata_i    (rdata),
    .rresp_i    (rresp),
    .rd_valid_o (rd_valid),
    .rd_o       (rd_word),
    .rd_ready_i (rd_ready)
  );

  axil_sram #(
    .WORDS (`BB_MEM_WORDS)
  ) axil_sram_inst (
    .clock     (clock),
    .reset     (reset),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .bresp_o   (bresp),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  response_packer response_packer_inst (
    .clock        (clock),
    .reset        (reset),
    .rd_valid_i   (rd_valid),
    .rd_i         (rd_word),
    .rd_ready_o   (rd_ready),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .beat_ready_i (beat_ready)
  );

  stream_fifo #(
    .payload_t (stream_beat_t),
    .DEPTH     (`BB_IN_FIFO_DEPTH)
  ) in_fifo (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (beat_valid),
    .in_data_i   (beat),
    .in_ready_o  (beat_ready),
    .out_valid_o (m_tvalid_o),
    .out_data_o  (in_beat),
    .out_ready_i (m_tready_i)
  );

endmodule

//--- command_parser.sv
`include "bulk_bridge_consts.svh"

module command_parser
  import bulk_bridge_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       s_tvalid_i,
  input  logic [7:0] s_tdata_i,
  output logic       s_tready_o,
  output logic       op_valid_o,
  output mem_op_t    op_o,
  input  logic       op_ready_i
);

  typedef enum logic [1:0] {ST_HDR, ST_WDATA, ST_READ} state_t;

  state_t                state;
  logic [1:0]            hdr_idx;
  logic [1:0]            byte_idx;
  logic [7:0]            opcode_q;
  logic [7:0]            words_left;
  logic [`BB_ADDR_W-3:0] word_addr;
  logic [23:0]           word_buf;
  logic                  can_emit;
  logic                  accept;

  function automatic mem_op_t make_op(input logic rd, input logic last,
                                      input logic [`BB_ADDR_W-3:0] waddr,
                                      input logic [`BB_DATA_W-1:0] data);
    mem_op_t op;
    op.is_read   = rd;
    op.last_word = last;
    op.addr      = {waddr, 2'b00};
    op.wdata     = data;
    return op;
  endfunction

  // Bytes stall while an op waits that the queue cannot take
  assign can_emit   = !op_valid_o || op_ready_i;
  assign s_tready_o = (state != ST_READ) && can_emit;
  assign accept     = s_tvalid_i && s_tready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_HDR;
      hdr_idx    <= 2'd0;
      byte_idx   <= 2'd0;
      words_left <= 8'd0;
      op_valid_o <= 1'b0;
    end else begin
      if (op_valid_o && op_ready_i) begin
        op_valid_o <= 1'b0;
      end
      case (state)
        ST_HDR: begin
          if (accept) begin
            hdr_idx <= hdr_idx + 2'd1;
            case (hdr_idx)
              2'd0: opcode_q <= s_tdata_i;
              2'd1: word_addr[7:0] <= s_tdata_i;
              2'd2: word_addr[15:8] <= s_tdata_i;
              default: begin
                if (opcode_q == `BB_OPC_READ) begin
                  // First read word goes out right away
                  op_valid_o <= 1'b1;
                  op_o       <= make_op(1'b1, s_tdata_i == 8'd1, word_addr, '0);
                  word_addr  <= word_addr + 1'b1;
                  words_left <= s_tdata_i - 8'd1;
                  state      <= (s_tdata_i == 8'd1) ? ST_HDR : ST_READ;
                end else begin
                  words_left <= s_tdata_i;
                  byte_idx   <= 2'd0;
                  state      <= ST_WDATA;
                end
              end
            endcase
          end
        end
        ST_WDATA: begin
          if (accept) begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) begin
              op_valid_o <= 1'b1;
              op_o       <= make_op(1'b0, 1'b0, word_addr, {s_tdata_i, word_buf});
              word_addr  <= word_addr + 1'b1;
              words_left <= words_left - 8'd1;
              if (words_left == 8'd1) begin
                state <= ST_HDR;
              end
            end else begin
              // Little-endian, so each byte shifts in from the top
              word_buf <= {s_tdata_i, word_buf[23:8]};
            end
          end
        end
        default: begin
          if (can_emit) begin
            op_valid_o <= 1'b1;
            op_o       <= make_op(1'b1, words_left == 8'd1, word_addr, '0);
            word_addr  <= word_addr + 1'b1;
            words_left <= words_left - 8'd1;
            if (words_left == 8'd1) begin
              state <= ST_HDR;
            end
          end
        end
      endcase
    end
  end

  a_opcode_known: assert property (@(posedge clock) disable iff (reset)
    (accept && state == ST_HDR && hdr_idx == 2'd0) |->
    (s_tdata_i == `BB_OPC_WRITE || s_tdata_i == `BB_OPC_READ));

endmodule

//--- list.f
+incdir+.
bulk_bridge_pkg.sv
stream_fifo.sv
command_parser.sv
axil_master.sv
axil_sram.sv
response_packer.sv
bulk_bridge_top.sv
tb_bulk_bridge.sv

//--- response_packer.sv
`include "bulk_bridge_consts.svh"

module response_packer
  import bulk_bridge_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         rd_valid_i,
  input  rd_word_t     rd_i,
  output logic         rd_ready_o,
  output logic         beat_valid_o,
  output stream_beat_t beat_o,
  input  logic         beat_ready_i
);

  logic [`BB_DATA_W-1:0] word_q;
  logic                  last_q;
  logic [1:0]            byte_idx;
  logic                  busy;
  logic                  beat_done;

  assign beat_done = beat_valid_o && beat_ready_i;

  // Next word may load as the final byte of the current one leaves
  assign rd_ready_o = !busy || (byte_idx == 2'd3 && beat_ready_i);

  assign beat_valid_o = busy;
  assign beat_o.data  = word_q[8*byte_idx +: 8];
  assign beat_o.last  = last_q && (byte_idx == 2'd3);

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      byte_idx <= 2'd0;
    end else begin
      if (beat_done) begin
        byte_idx <= byte_idx + 2'd1;
        if (byte_idx == 2'd3) begin
          busy <= 1'b0;
        end
      end
      if (rd_valid_i && rd_ready_o) begin
        busy     <= 1'b1;
        byte_idx <= 2'd0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_valid_i && rd_ready_o) begin
      word_q <= rd_i.data;
      last_q <= rd_i.last_word;
    end
  end

endmodule

//--- stream_fifo.sv
module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count != (PTR_W + 1)'(DEPTH));
  assign out_valid_o = (count != '0);
  assign out_data_o  = mem[rd_ptr];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  a_count_bound: assert property (@(posedge clock) disable iff (reset)
    count <= (PTR_W + 1)'(DEPTH));

endmodule

//--- tb_bulk_bridge.sv
`include "bulk_bridge_consts.svh"

module tb_bulk_bridge;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 2000;

  logic       clock;
  logic       reset;
  logic       s_tvalid_i;
  logic [7:0] s_tdata_i;
  logic       s_tlast_i;
  logic       s_tready_o;
  logic       m_tvalid_o;
  logic [7:0] m_tdata_o;
  logic       m_tlast_o;
  logic       m_tready_i;

  // Expected IN beats as {last, data}, oldest first
  logic [8:0] exp_q[$];
  string      rd_name_q[$];
  int         rx_idx = 0;
  int         rd_errs = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         error_count = 0;
  int         gap_seed = 32'hd25387b5;
  int         ready_seed = 32'hd25387b5;

  bulk_bridge_top bulk_bridge_top_inst (
    .clock      (clock),
    .reset      (reset),
    .s_tvalid_i (s_tvalid_i),
    .s_tdata_i  (s_tdata_i),
    .s_tlast_i  (s_tlast_i),
    .s_tready_o (s_tready_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tdata_o  (m_tdata_o),
    .m_tlast_o  (m_tlast_o),
    .m_tready_i (m_tready_i)
  );

  always begin
    #5 clock = ~clock;
  end

  function automatic void report_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s: %0d mismatches", name, errs);
      tests_failed++;
      error_count += errs;
    end
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    $display("Simulation FAILED");
    $finish;
  endtask

  // One OUT byte, then a short random idle gap
  task automatic send_byte(input logic [7:0] data, input logic last);
    int waited;
    int gap;
    waited = 0;
    s_tvalid_i = 1'b1;
    s_tdata_i  = data;
    s_tlast_i  = last;
    @(negedge clock);
    while (!s_tready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout waiting for s_tready_o on the OUT stream");
      end
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    gap = {$random(gap_seed)} % 3;
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic check_idle_after_reset();
    int errs;
    errs = 0;
    repeat (8) begin
      @(negedge clock);
      if (m_tvalid_o !== 1'b0) begin
        $display("ERR reset_idle: m_tvalid_o expected 0 actual %b", m_tvalid_o);
        errs++;
      end
      if (s_tready_o !== 1'b1) begin
        $display("ERR reset_idle: s_tready_o expected 1 actual %b", s_tready_o);
        errs++;
      end
    end
    @(posedge clock);
    #1;
    report_test("reset_idle", errs);
  endtask

  // Host side of IN drops ready about one cycle in three
  always @(posedge clock) begin
    #1;
    m_tready_i = ({$random(ready_seed)} % 3) != 0;
  end

  // IN bytes are taken mid-cycle where valid and ready have settled
  always @(negedge clock) begin
    logic [8:0] want;
    if (!reset && m_tvalid_o && m_tready_i) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected IN byte %h arrived with no read pending", m_tdata_o);
        error_count++;
      end else begin
        want = exp_q.pop_front();
        if (m_tdata_o !== want[7:0]) begin
          $display("ERR %s: byte %0d data expected %h actual %h",
                   rd_name_q[0], rx_idx, want[7:0], m_tdata_o);
          rd_errs++;
        end
        if (m_tlast_o !== want[8]) begin
          $display("ERR %s: byte %0d tlast expected %b actual %b",
                   rd_name_q[0], rx_idx, want[8], m_tlast_o);
          rd_errs++;
        end
        rx_idx++;
        if (want[8]) begin
          report_test(rd_name_q.pop_front(), rd_errs);
          rx_idx  = 0;
          rd_errs = 0;
        end
      end
    end
  end

  initial begin
    int         fd;
    int         code;
    int         addr;
    int         count;
    int         value;
    int         waited;
    string      name;
    string      kind;
    string      rest;
    logic [7:0] cmd_q[$];

    clock      = 1'b0;
    reset      = 1'b1;
    s_tvalid_i = 1'b0;
    s_tdata_i  = 8'h00;
    s_tlast_i  = 1'b0;
    m_tready_i = 1'b0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    check_idle_after_reset();

    fd = $fopen("bulk_bridge_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open bulk_bridge_patterns.txt");
    end
    while ($fscanf(fd, "%s", name) == 1) begin
      if (name.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%s %h %h", kind, addr, count);
        if (code != 3 || (kind != "R" && kind != "W")) begin
          abort_run($sformatf("Pattern line %s has a broken header", name));
        end
        cmd_q.delete();
        cmd_q.push_back((kind == "R") ? `BB_OPC_READ : `BB_OPC_WRITE);
        cmd_q.push_back(addr[7:0]);
        cmd_q.push_back(addr[15:8]);
        cmd_q.push_back(count[7:0]);
        if (kind == "R") begin
          rd_name_q.push_back(name);
        end
        for (int i = 0; i < 4 * count; i++) begin
          code = $fscanf(fd, "%h", value);
          if (code != 1) begin
            abort_run($sformatf("Pattern line %s has too few bytes", name));
          end
          // Read answers end with tlast on the final byte
          if (kind == "R") begin
            exp_q.push_back({i == 4 * count - 1, value[7:0]});
          end else begin
            cmd_q.push_back(value[7:0]);
          end
        end
        foreach (cmd_q[i]) begin
          send_byte(cmd_q[i], i == cmd_q.size() - 1);
        end
        if (kind == "W") begin
          $display("done %s: %0d words written at %h", name, count, addr);
          tests_run++;
        end
      end
    end
    $fclose(fd);

    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout waiting for read data on the IN stream");
      end
      @(posedge clock);
    end
    // Quiet stretch so stray extra bytes get noticed
    repeat (20) @(posedge clock);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
